/* hw/i2c_bridge_defines.svh */
// Buffer depths and SCL divider counts for the I2C bridge, included by every RTL file that sizes them
`ifndef I2C_BRIDGE_DEFINES_SVH
`define I2C_BRIDGE_DEFINES_SVH

// ==============================
// Buffers
// ==============================
`define I2C_WR_BUF_DEPTH 128
`define I2C_RD_BUF_DEPTH 128

// ==============================
// SCL quarter-period counts, 25 MHz clk
// ==============================
`define I2C_DIV_W     20
`define I2C_DIV_50K   20'd124
`define I2C_DIV_100K  20'd61
`define I2C_DIV_200K  20'd30
`define I2C_DIV_400K  20'd14
`define I2C_DIV_RESET `I2C_DIV_100K

`endif

/* hw/i2c_cmd_pkg.sv */
// Host command and upload types of the I2C bridge, imported wherever host traffic is decoded
package i2c_cmd_pkg;

    // Command type byte sent by the host
    typedef enum logic [7:0] {
        OP_CONFIG = 8'h04,
        OP_WRITE  = 8'h05,
        OP_READ   = 8'h06
    } i2c_opcode_e;

    // Framed command stream, one body byte per cmd_data_valid
    typedef struct packed {
        logic [7:0]  cmd_type;
        logic [15:0] cmd_length;       // Body bytes in the command
        logic [7:0]  cmd_data;
        logic [15:0] cmd_data_index;   // Zero-based body position
        logic        cmd_start;
        logic        cmd_data_valid;
        logic        cmd_done;
    } cmd_stream_t;

    // Read data returned to the host
    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } upload_t;

endpackage

/* hw/i2c_bus_pkg.sv */
// Transfer request, response and bit phase types between the command handler and the bus engine
package i2c_bus_pkg;

    typedef enum logic {XFER_WR, XFER_RD} xfer_op_e;

    typedef struct packed {
        logic        start;     // One-cycle pulse
        xfer_op_e    op;
        logic [15:0] reg_addr;
        logic [7:0]  wdata;
    } xfer_req_t;

    typedef struct packed {
        logic       done;       // One pulse per transfer
        logic       nack;
        logic [7:0] rdata;
    } xfer_rsp_t;

    // Phase of the bus engine, each lasting whole bit times
    typedef enum logic [2:0] {
        B_IDLE, B_START, B_SHIFT, B_ACK, B_RESTART, B_STOP
    } bit_state_e;

endpackage

/* hw/i2c_cfg_regs.sv */
// Configure-command decoder holding the target address and SCL divider fed to the bus engine
`timescale 1ns/1ps
`include "i2c_bridge_defines.svh"

module i2c_cfg_regs import i2c_cmd_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cmd_stream_t           cmd,
    output logic [6:0]            dev_addr,
    output logic [`I2C_DIV_W-1:0] scl_div
);

    logic        is_cfg;    // Current command is a configure
    logic [15:0] cfg_len;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_cfg   <= 1'b0;
            dev_addr <= 7'h50;
            scl_div  <= `I2C_DIV_RESET;
        end else begin
            if (cmd.cmd_start) begin
                is_cfg <= (cmd.cmd_type == OP_CONFIG);
            end else if (cmd.cmd_done) begin
                is_cfg <= 1'b0;
            end
            if (is_cfg && cmd.cmd_data_valid) begin
                case (cmd.cmd_data_index)
                    16'd0: dev_addr <= cmd.cmd_data[6:0];
                    16'd1: begin
                        case (cmd.cmd_data)
                            8'd0: scl_div <= `I2C_DIV_50K;
                            8'd1: scl_div <= `I2C_DIV_100K;
                            8'd2: scl_div <= `I2C_DIV_200K;
                            8'd3: scl_div <= `I2C_DIV_400K;
                            default: ;                 // Unknown code keeps the old speed
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd.cmd_start) begin
            cfg_len <= cmd.cmd_length;
        end
    end

    // Body bytes beyond the speed code must stay inside the announced length
    a_cfg_index_in_len: assert property (@(posedge clk) disable iff (!rst_n)
        (is_cfg && cmd.cmd_data_valid && cmd.cmd_data_index > 16'd1)
            |-> (cmd.cmd_data_index < cfg_len));

endmodule

/* hw/i2c_byte_engine.sv */
// Open-drain I2C master running one single-byte register write or read with 16-bit addressing
`timescale 1ns/1ps
`include "i2c_bridge_defines.svh"

module i2c_byte_engine import i2c_bus_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  xfer_req_t             req,
    input  logic [6:0]            dev_addr,
    input  logic [`I2C_DIV_W-1:0] scl_div,
    output xfer_rsp_t             rsp,
    inout  wire                   i2c_scl,
    inout  wire                   i2c_sda
);

    bit_state_e            state;
    logic [`I2C_DIV_W-1:0] div_cnt;
    logic [1:0]            quarter;
    logic                  tick;
    logic                  bit_end;
    logic [2:0]            bit_cnt;
    logic [2:0]            byte_idx;
    logic [7:0]            shifter;
    logic                  sample_bit;
    logic                  rx_byte;
    logic                  go_stop;
    logic                  go_restart;
    logic                  done_q;
    logic                  nack_q;
    logic                  scl_low;
    logic                  sda_low;
    xfer_op_e              op_q;
    logic [15:0]           addr_q;
    logic [7:0]            wdata_q;

    // Byte sent at each position of the sequence
    function automatic logic [7:0] seq_byte(input logic [2:0] idx);
        case (idx)
            3'd0:    return {dev_addr, 1'b0};
            3'd1:    return addr_q[15:8];
            3'd2:    return addr_q[7:0];
            3'd3:    return (op_q == XFER_WR) ? wdata_q : {dev_addr, 1'b1};
            default: return 8'hFF;                  // Receive byte, SDA left released
        endcase
    endfunction

    assign tick       = (div_cnt >= scl_div);
    assign bit_end    = tick && (quarter == 2'd3);
    assign rx_byte    = (op_q == XFER_RD) && (byte_idx == 3'd4);
    assign go_stop    = rx_byte || sample_bit || (op_q == XFER_WR && byte_idx == 3'd3);
    assign go_restart = (op_q == XFER_RD) && (byte_idx == 3'd2);

    assign i2c_scl = scl_low ? 1'b0 : 1'bz;
    assign i2c_sda = sda_low ? 1'b0 : 1'bz;
    assign rsp     = '{done: done_q, nack: nack_q, rdata: shifter};

    // ==============================
    // Quarter-period timebase
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            quarter <= 2'd0;
        end else if (state == B_IDLE) begin
            div_cnt <= '0;
            quarter <= 2'd0;
        end else if (tick) begin
            div_cnt <= '0;
            quarter <= quarter + 2'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // ==============================
    // Bit phase FSM
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= B_IDLE;
            bit_cnt  <= 3'd7;
            byte_idx <= 3'd0;
            done_q   <= 1'b0;
            nack_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                B_IDLE: if (req.start) begin
                    byte_idx <= 3'd0;
                    state    <= B_START;
                end
                B_START, B_RESTART: if (bit_end) begin
                    bit_cnt <= 3'd7;
                    state   <= B_SHIFT;
                end
                B_SHIFT: if (bit_end) begin
                    if (bit_cnt == 3'd0) state <= B_ACK;
                    else bit_cnt <= bit_cnt - 3'd1;
                end
                B_ACK: if (bit_end) begin
                    if (go_stop) begin
                        nack_q <= !rx_byte && sample_bit;  // Target left SDA high
                        state  <= B_STOP;
                    end else if (go_restart) begin
                        byte_idx <= 3'd3;
                        state    <= B_RESTART;
                    end else begin
                        byte_idx <= byte_idx + 3'd1;
                        bit_cnt  <= 3'd7;
                        state    <= B_SHIFT;
                    end
                end
                B_STOP: if (bit_end) begin
                    done_q <= 1'b1;
                    state  <= B_IDLE;
                end
                default: state <= B_IDLE;
            endcase
        end
    end

    // Request latch and shift register
    always_ff @(posedge clk) begin
        if (state == B_IDLE && req.start) begin
            op_q    <= req.op;
            addr_q  <= req.reg_addr;
            wdata_q <= req.wdata;
        end
        if (tick && quarter == 2'd1) sample_bit <= i2c_sda;   // Middle of SCL high
        if (bit_end) begin
            case (state)
                B_START, B_RESTART: shifter <= seq_byte(byte_idx);
                B_SHIFT: shifter <= {shifter[6:0], sample_bit};
                B_ACK: if (!go_stop && !go_restart) shifter <= seq_byte(byte_idx + 3'd1);
                default: ;
            endcase
        end
    end

    // Line levels per quarter, SCL high in quarters 1 and 2 of a data bit
    always_comb begin
        scl_low = 1'b0;
        sda_low = 1'b0;
        case (state)
            B_START: begin
                scl_low = (quarter == 2'd3);
                sda_low = quarter[1];                      // SDA falls while SCL high
            end
            B_RESTART: begin
                scl_low = quarter inside {2'd0, 2'd3};
                sda_low = quarter[1];
            end
            B_SHIFT: begin
                scl_low = quarter inside {2'd0, 2'd3};
                sda_low = !rx_byte && !shifter[7];
            end
            B_ACK:   scl_low = quarter inside {2'd0, 2'd3};  // Master NACKs the read byte
            B_STOP: begin
                scl_low = (quarter == 2'd0);
                sda_low = !quarter[1];                     // SDA rises while SCL high
            end
            default: ;
        endcase
    end

    a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
        req.start |-> (state == B_IDLE));

endmodule

/* hw/i2c_cmd_handler.sv */
// Write and read command parser that buffers data, sequences byte transfers and uploads read data
`timescale 1ns/1ps
`include "i2c_bridge_defines.svh"

module i2c_cmd_handler import i2c_cmd_pkg::*, i2c_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cmd_stream_t cmd,
    input  logic        upload_ready,
    input  xfer_rsp_t   rsp,
    output logic        cmd_ready,
    output xfer_req_t   req,
    output upload_t     upload,
    output logic        upload_active,
    output logic        xfer_error
);

    localparam int WR_AW = $clog2(`I2C_WR_BUF_DEPTH);
    localparam int RD_AW = $clog2(`I2C_RD_BUF_DEPTH);

    typedef enum logic [2:0] {
        H_IDLE, H_PARSE_WR, H_PARSE_RD, H_EXEC_WR, H_EXEC_RD, H_UPLOAD
    } h_state_e;

    typedef enum logic [1:0] {U_IDLE, U_SEND, U_WAIT} u_state_e;

    h_state_e    state;
    u_state_e    u_state;
    logic [15:0] reg_addr;
    logic [15:0] data_len;     // Bytes to write or read
    logic [15:0] data_ptr;
    logic        busy;         // Transfer outstanding at the engine
    logic        req_start;
    logic [7:0]  wdata_q;
    logic [7:0]  up_data;
    logic [15:0] wr_idx;
    logic        more;
    logic [7:0]  wr_buf [`I2C_WR_BUF_DEPTH];
    logic [7:0]  rd_buf [`I2C_RD_BUF_DEPTH];

    assign wr_idx        = cmd.cmd_data_index - 16'd2;
    assign more          = (data_ptr < data_len);
    assign cmd_ready     = (state == H_IDLE);
    assign upload_active = (state == H_UPLOAD);
    assign upload        = '{valid: (u_state == U_SEND) && upload_ready, data: up_data};
    assign req = '{start: req_start, op: (state == H_EXEC_RD) ? XFER_RD : XFER_WR,
                   reg_addr: reg_addr, wdata: wdata_q};

    // ==============================
    // Command and transfer sequencing
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= H_IDLE;
            u_state    <= U_IDLE;
            reg_addr   <= '0;
            data_len   <= '0;
            data_ptr   <= '0;
            busy       <= 1'b0;
            req_start  <= 1'b0;
            xfer_error <= 1'b0;
        end else begin
            req_start  <= 1'b0;
            xfer_error <= 1'b0;
            case (state)
                H_IDLE: begin
                    data_ptr <= '0;
                    busy     <= 1'b0;
                    if (cmd.cmd_start && cmd.cmd_type == OP_WRITE && cmd.cmd_length >= 16'd3
                        && cmd.cmd_length <= `I2C_WR_BUF_DEPTH + 2) begin
                        data_len <= cmd.cmd_length - 16'd2;
                        state    <= H_PARSE_WR;
                    end else if (cmd.cmd_start && cmd.cmd_type == OP_READ
                                 && cmd.cmd_length == 16'd4) begin
                        state <= H_PARSE_RD;
                    end
                end
                H_PARSE_WR: begin
                    if (cmd.cmd_data_valid && cmd.cmd_data_index == 16'd0) reg_addr[15:8] <= cmd.cmd_data;
                    if (cmd.cmd_data_valid && cmd.cmd_data_index == 16'd1) reg_addr[7:0] <= cmd.cmd_data;
                    if (cmd.cmd_done) state <= H_EXEC_WR;
                end
                H_PARSE_RD: begin
                    if (cmd.cmd_data_valid) begin
                        case (cmd.cmd_data_index)
                            16'd0: reg_addr[15:8] <= cmd.cmd_data;
                            16'd1: reg_addr[7:0]  <= cmd.cmd_data;
                            16'd2: data_len[15:8] <= cmd.cmd_data;
                            16'd3: data_len[7:0]  <= cmd.cmd_data;
                            default: ;
                        endcase
                    end
                    if (cmd.cmd_done) begin
                        // Count must fit the read buffer
                        if (data_len == 16'd0 || data_len > `I2C_RD_BUF_DEPTH) state <= H_IDLE;
                        else state <= H_EXEC_RD;
                    end
                end
                H_EXEC_WR, H_EXEC_RD: begin
                    if (!busy) begin
                        if (more) begin
                            req_start <= 1'b1;
                            busy      <= 1'b1;
                        end else begin
                            data_ptr <= '0;
                            state    <= (state == H_EXEC_RD) ? H_UPLOAD : H_IDLE;
                        end
                    end else if (rsp.done) begin
                        busy <= 1'b0;
                        if (rsp.nack) begin
                            xfer_error <= 1'b1;           // Abandon the rest of the command
                            state      <= H_IDLE;
                        end else begin
                            data_ptr <= data_ptr + 16'd1;
                            reg_addr <= reg_addr + 16'd1;
                        end
                    end
                end
                H_UPLOAD: if (!more && u_state == U_IDLE) state <= H_IDLE;
                default: state <= H_IDLE;
            endcase

            // Upload pacing, at least two quiet cycles after each byte
            case (u_state)
                U_IDLE: if (state == H_UPLOAD && more) u_state <= U_SEND;
                U_SEND: if (upload_ready) begin
                    data_ptr <= data_ptr + 16'd1;
                    u_state  <= U_WAIT;
                end
                U_WAIT:  u_state <= U_IDLE;
                default: u_state <= U_IDLE;
            endcase
        end
    end

    // Buffers and data staging
    always_ff @(posedge clk) begin
        if (state == H_PARSE_WR && cmd.cmd_data_valid && wr_idx < `I2C_WR_BUF_DEPTH) begin
            wr_buf[wr_idx[WR_AW-1:0]] <= cmd.cmd_data;
        end
        if (state == H_EXEC_RD && busy && rsp.done && !rsp.nack) begin
            rd_buf[data_ptr[RD_AW-1:0]] <= rsp.rdata;
        end
        wdata_q <= wr_buf[data_ptr[WR_AW-1:0]];
        if (u_state == U_IDLE) up_data <= rd_buf[data_ptr[RD_AW-1:0]];
    end

    a_valid_in_upload: assert property (@(posedge clk) disable iff (!rst_n)
        upload.valid |-> upload_active);

endmodule

/* hw/i2c_bridge_top.sv */
// I2C register bridge top level connecting host commands, configuration and the bus engine
`timescale 1ns/1ps
`include "i2c_bridge_defines.svh"

module i2c_bridge_top import i2c_cmd_pkg::*, i2c_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  cmd_stream_t cmd,
    input  logic        upload_ready,
    output logic        cmd_ready,
    output upload_t     upload,
    output logic        upload_active,
    output logic        xfer_error,
    inout  wire         i2c_scl,
    inout  wire         i2c_sda
);

    logic [6:0]            dev_addr;
    logic [`I2C_DIV_W-1:0] scl_div;
    xfer_req_t             req;
    xfer_rsp_t             rsp;

    i2c_cmd_handler i_cmd_handler (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .upload_ready  (upload_ready),
        .rsp           (rsp),
        .cmd_ready     (cmd_ready),
        .req           (req),
        .upload        (upload),
        .upload_active (upload_active),
        .xfer_error    (xfer_error)
    );

    i2c_cfg_regs i_cfg_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd      (cmd),
        .dev_addr (dev_addr),
        .scl_div  (scl_div)
    );

    i2c_byte_engine i_byte_engine (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .dev_addr (dev_addr),
        .scl_div  (scl_div),
        .rsp      (rsp),
        .i2c_scl  (i2c_scl),
        .i2c_sda  (i2c_sda)
    );

endmodule

/* tb/tb_clk_gen.sv */
// Testbench clock and reset source, instantiated once by the testbench top
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released just after a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

/* tb/i2c_slave_model.sv */
// Behavioral I2C target with a 16-bit register pointer, auto-increment and 256 bytes of memory
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] DEV_ADDR = 7'h50
) (
    input wire scl,
    inout wire sda
);

    logic [7:0]  mem [256];
    logic [7:0]  shreg;
    logic [15:0] ptr;          // Register pointer, low byte selects memory
    int          bit_cnt;      // 8 marks the ACK slot, 9 its high phase seen
    int          byte_num;
    logic        active;
    logic        addr_rd;
    logic        rd_mode;
    logic        m_ack;
    logic        sda_drv;

    assign sda = sda_drv ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 37 + 11);       // Address-dependent fill
        end
        sda_drv  = 1'b0;
        active   = 1'b0;
        rd_mode  = 1'b0;
        addr_rd  = 1'b0;
        m_ack    = 1'b0;
        bit_cnt  = 0;
        byte_num = 0;
        ptr      = '0;
    end

    // ==============================
    // START and STOP detection
    // ==============================
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active   = 1'b1;
            rd_mode  = 1'b0;
            bit_cnt  = 0;
            byte_num = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b0;
            sda_drv = 1'b0;
        end
    end

    // Sample on the rising SCL edge
    always @(posedge scl) begin
        if (active && bit_cnt < 8) begin
            if (!rd_mode) shreg = {shreg[6:0], sda === 1'b1};
            bit_cnt++;
        end else if (active && bit_cnt == 8) begin
            m_ack   = (sda === 1'b0);       // Master answer to a read byte
            bit_cnt = 9;
        end
    end

    // ==============================
    // Drive on the falling SCL edge
    // ==============================
    always @(negedge scl) begin
        if (!active) begin
            sda_drv = 1'b0;
        end else if (bit_cnt == 8) begin
            if (rd_mode) begin
                sda_drv = 1'b0;             // Let the master answer
            end else if (byte_num == 0) begin
                addr_rd = shreg[0];
                active  = (shreg[7:1] == DEV_ADDR);
                sda_drv = active;
            end else begin
                if (byte_num == 1) begin
                    ptr[15:8] = shreg;
                end else if (byte_num == 2) begin
                    ptr[7:0] = shreg;
                end else begin
                    mem[ptr[7:0]] = shreg;
                    ptr           = ptr + 16'd1;
                end
                sda_drv = 1'b1;
            end
        end else if (bit_cnt == 9) begin
            sda_drv = 1'b0;
            bit_cnt = 0;
            if (rd_mode && !m_ack) begin
                active = 1'b0;              // Master ended the read
            end else if (byte_num == 0 && addr_rd) begin
                rd_mode = 1'b1;
            end
            byte_num++;
            if (active && rd_mode) begin
                shreg   = mem[ptr[7:0]];
                ptr     = ptr + 16'd1;
                sda_drv = !shreg[7];
            end
        end else if (rd_mode && bit_cnt > 0) begin
            sda_drv = !shreg[7 - bit_cnt];
        end
    end

endmodule

/* tb/tb_i2c_bridge.sv */
// Testbench top for the I2C bridge, applying a stimulus table against a behavioral target
`timescale 1ns/1ps
`include "i2c_bridge_defines.svh"

module tb_i2c_bridge import i2c_cmd_pkg::*; ();

    localparam int XFER_CYCLES  = 4000;    // One byte transfer at speed code 3, with margin
    localparam int QUIET_CYCLES = 400;
    localparam int N_ENTRIES    = 19;

    typedef enum logic [1:0] {T_CFG, T_WR, T_RD, T_RD_BAD} test_op_e;

    typedef struct packed {
        test_op_e    op;
        logic [6:0]  dev;
        logic [7:0]  speed;
        logic [15:0] reg_addr;
        logic [15:0] count;      // Data bytes to write or read
        logic        exp_nack;
    } entry_t;

    logic        clk;
    logic        rst_n;
    cmd_stream_t cmd;
    logic        upload_ready;
    logic        cmd_ready;
    upload_t     upload;
    logic        upload_active;
    logic        xfer_error;
    wire         i2c_scl;
    wire         i2c_sda;

    entry_t      stim [N_ENTRIES];
    logic [7:0]  ref_mem [256];
    logic [7:0]  body_q [$];
    logic [7:0]  upq [$];       // Uploaded bytes not yet checked
    logic [31:0] lcg_state = 32'd10;
    int          hold_low  = 0;
    int          err_count = 0;
    int          scl_falls = 0;

    pullup (i2c_scl);
    pullup (i2c_sda);

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(5)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    i2c_slave_model #(.DEV_ADDR(7'h50)) i_target (.scl(i2c_scl), .sda(i2c_sda));

    i2c_bridge_top i_i2c_bridge_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (cmd),
        .upload_ready  (upload_ready),
        .cmd_ready     (cmd_ready),
        .upload        (upload),
        .upload_active (upload_active),
        .xfer_error    (xfer_error),
        .i2c_scl       (i2c_scl),
        .i2c_sda       (i2c_sda)
    );

    // ==============================
    // Reporting and helpers
    // ==============================
    task automatic halt_run();
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        halt_run();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        halt_run();
    endtask

    function automatic logic [7:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    task automatic drive_cycle();
        @(posedge clk);
        #2;
    endtask

    // Upload pulses and error pulses, sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n && upload.valid === 1'b1) begin
            assert (upload_ready === 1'b1)
                else report_mismatch("upload valid while upload_ready low");
            upq.push_back(upload.data);
        end
        if (rst_n && xfer_error === 1'b1) err_count++;
    end

    always @(negedge i2c_scl) scl_falls++;

    // Start pulse, body bytes from body_q, then done
    task automatic send_command(input logic [7:0] ctype);
        drive_cycle();
        cmd            = '0;
        cmd.cmd_type   = ctype;
        cmd.cmd_length = body_q.size();
        cmd.cmd_start  = 1'b1;
        for (int i = 0; i < body_q.size(); i++) begin
            drive_cycle();
            cmd.cmd_start      = 1'b0;
            cmd.cmd_data_valid = 1'b1;
            cmd.cmd_data       = body_q[i];
            cmd.cmd_data_index = i[15:0];
        end
        drive_cycle();
        cmd.cmd_start      = 1'b0;
        cmd.cmd_data_valid = 1'b0;
        cmd.cmd_done       = 1'b1;
        drive_cycle();
        cmd.cmd_done = 1'b0;
    endtask

    task automatic wait_cmd_ready(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (cmd_ready !== 1'b1) begin
            if (n >= limit) report_timeout("cmd_ready");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_error_pulse(input int base, input int limit);
        int n;
        n = 0;
        while (err_count == base) begin
            if (n >= limit) report_timeout("the error pulse");
            @(negedge clk);
            n++;
        end
    endtask

    task automatic wait_upload_end(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (upload_active !== 1'b0) begin
            if (n >= limit) report_timeout("upload_active to fall");
            @(negedge clk);
            n++;
        end
    endtask

    // Random low stretches on upload_ready
    task automatic pace_upload_ready();
        drive_cycle();
        if (hold_low > 0) begin
            upload_ready = 1'b0;
            hold_low--;
        end else begin
            upload_ready = 1'b1;
            if (lcg_next() < 8'd40) hold_low = 1 + lcg_next() % 8;
        end
    endtask

    task automatic wait_upload_byte(output logic [7:0] data, input int limit);
        int n;
        n = 0;
        while (upq.size() == 0) begin
            if (n >= limit) report_timeout("an upload byte");
            pace_upload_ready();
            n++;
        end
        data = upq.pop_front();
    endtask

    task automatic check_quiet_bus(input int falls_base);
        wait_cmd_ready(100);
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (cmd_ready === 1'b1 && i2c_scl === 1'b1 && i2c_sda === 1'b1)
                else report_mismatch("rejected command started a transfer");
        end
        assert (scl_falls == falls_base) else report_mismatch("SCL toggled for a rejected command");
    endtask

    task automatic load_table();
        stim[0]  = '{T_CFG,    7'h50, 8'd3, 16'h0000, 16'd0,   1'b0};
        stim[1]  = '{T_WR,     7'h50, 8'd0, 16'h0010, 16'd4,   1'b0};
        stim[2]  = '{T_RD,     7'h50, 8'd0, 16'h0010, 16'd4,   1'b0};
        stim[3]  = '{T_WR,     7'h50, 8'd0, 16'h1234, 16'd17,  1'b0};
        stim[4]  = '{T_RD,     7'h50, 8'd0, 16'h1230, 16'd24,  1'b0};
        stim[5]  = '{T_CFG,    7'h50, 8'd9, 16'h0000, 16'd0,   1'b0};  // Bad speed code
        stim[6]  = '{T_WR,     7'h50, 8'd0, 16'h00C0, 16'd128, 1'b0};
        stim[7]  = '{T_RD,     7'h50, 8'd0, 16'h0100, 16'd128, 1'b0};
        stim[8]  = '{T_WR,     7'h50, 8'd0, 16'h0040, 16'd0,   1'b0};  // Length 2
        stim[9]  = '{T_WR,     7'h50, 8'd0, 16'h0060, 16'd129, 1'b0};
        stim[10] = '{T_RD_BAD, 7'h50, 8'd0, 16'h0010, 16'd4,   1'b0};
        stim[11] = '{T_RD,     7'h50, 8'd0, 16'h0010, 16'd0,   1'b0};
        stim[12] = '{T_CFG,    7'h23, 8'd3, 16'h0000, 16'd0,   1'b0};  // No target there
        stim[13] = '{T_WR,     7'h23, 8'd0, 16'h0020, 16'd3,   1'b1};
        stim[14] = '{T_RD,     7'h23, 8'd0, 16'h0020, 16'd2,   1'b1};
        stim[15] = '{T_CFG,    7'h50, 8'd3, 16'h0000, 16'd0,   1'b0};
        stim[16] = '{T_RD,     7'h50, 8'd0, 16'h001E, 16'd8,   1'b0};
        stim[17] = '{T_WR,     7'h50, 8'd0, 16'h005A, 16'd1,   1'b0};
        stim[18] = '{T_RD,     7'h50, 8'd0, 16'h0058, 16'd16,  1'b0};
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        entry_t      ent;
        logic        accepted;
        int          err_base;
        int          falls_base;
        logic [15:0] addr;
        logic [7:0]  got;

        cmd          = '0;
        upload_ready = 1'b1;
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = 8'(i * 37 + 11);   // Same fill as the target
        end
        load_table();
        @(posedge rst_n);

        for (int e = 0; e < N_ENTRIES; e++) begin
            ent      = stim[e];
            accepted = (ent.op == T_WR && ent.count != 0 && ent.count <= `I2C_WR_BUF_DEPTH)
                       || (ent.op == T_RD && ent.count != 0 && ent.count <= `I2C_RD_BUF_DEPTH);
            wait_cmd_ready(100);
            err_base   = err_count;
            falls_base = scl_falls;
            body_q.delete();
            if (ent.op == T_CFG) begin
                body_q.push_back({1'b0, ent.dev});
                body_q.push_back(ent.speed);
                send_command(OP_CONFIG);
            end else if (ent.op == T_WR) begin
                body_q.push_back(ent.reg_addr[15:8]);
                body_q.push_back(ent.reg_addr[7:0]);
                for (int k = 0; k < ent.count; k++) begin
                    body_q.push_back(lcg_next());
                end
                send_command(OP_WRITE);
                for (int k = 0; k < ent.count && accepted && !ent.exp_nack; k++) begin
                    addr               = ent.reg_addr + k[15:0];
                    ref_mem[addr[7:0]] = body_q[k + 2];
                end
            end else begin
                body_q.push_back(ent.reg_addr[15:8]);
                body_q.push_back(ent.reg_addr[7:0]);
                body_q.push_back(ent.count[15:8]);
                if (ent.op == T_RD) body_q.push_back(ent.count[7:0]);
                send_command(OP_READ);
            end

            if (ent.op == T_CFG) begin
                wait_cmd_ready(100);
            end else if (!accepted) begin
                check_quiet_bus(falls_base);
            end else if (ent.exp_nack) begin
                wait_error_pulse(err_base, XFER_CYCLES * 2);
                wait_cmd_ready(100);
                assert (err_count == err_base + 1) else report_mismatch("expected one error pulse");
                assert (upq.size() == 0) else report_mismatch("upload pulse after NACK");
            end else begin
                for (int k = 0; k < ent.count && ent.op == T_RD; k++) begin
                    wait_upload_byte(got, XFER_CYCLES * (ent.count + 2));
                    addr = ent.reg_addr + k[15:0];
                    assert (got === ref_mem[addr[7:0]])
                        else report_mismatch($sformatf("read at 0x%04h gave 0x%02h, expected 0x%02h",
                                                       addr, got, ref_mem[addr[7:0]]));
                end
                if (ent.op == T_RD) wait_upload_end(100);
                wait_cmd_ready(XFER_CYCLES * (ent.count + 2));
                drive_cycle();
                upload_ready = 1'b1;
                hold_low     = 0;
                assert (upq.size() == 0) else report_mismatch("more upload pulses than the count");
                assert (err_count == err_base) else report_mismatch("unexpected error pulse");
                assert (scl_falls > falls_base) else report_mismatch("no SCL activity");
            end
        end

        $display("all tests passed");
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/i2c_cmd_pkg.sv
hw/i2c_bus_pkg.sv
hw/i2c_cfg_regs.sv
hw/i2c_byte_engine.sv
hw/i2c_cmd_handler.sv
hw/i2c_bridge_top.sv
tb/tb_clk_gen.sv
tb/i2c_slave_model.sv
tb/tb_i2c_bridge.sv
